// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= rob_tb
SEED_LOG ?= sim.log
OBJ_DIR ?= obj_dir
FLAGS ?= --binary --timing --assert -Wno-fatal
FAIL_MSG := SOME TESTS FAILED
SOURCES := project.f $(wildcard logic/*.sv tests/*.sv)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with Verilator, run it, log to $(SEED_LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(SEED_LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP SEED_LOG OBJ_DIR FLAGS"

$(OBJ_DIR)/V$(TOP): $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f project.f

test: $(OBJ_DIR)/V$(TOP)
	@./$(OBJ_DIR)/V$(TOP) > $(SEED_LOG) 2>&1; status=$$?; cat $(SEED_LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(SEED_LOG); then \
		echo "Simulation failed, see $(SEED_LOG)"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(SEED_LOG)

// ==== logic/completion_cam.sv ====
`timescale 1ns/1ns
`default_nettype none

module completion_cam import isa_pkg::*; #(
	parameter int ROB_SIZE = 8,
	parameter int SS_SIZE = 2
) (
	input logic [SS_SIZE-1:0] cdb_valid,
	input phys_reg_t [SS_SIZE-1:0] cdb_tag,
	output logic [ROB_SIZE-1:0] cam_hits,
	rob_view_if.cam view
);

	// One compare per entry and CDB lane
	logic [ROB_SIZE-1:0][SS_SIZE-1:0] match;

	genvar gi, gk;
	generate
		for (gi = 0; gi < ROB_SIZE; gi++) begin : g_row
			for (gk = 0; gk < SS_SIZE; gk++) begin : g_lane
				assign match[gi][gk] = cdb_valid[gk]
					&& (cdb_tag[gk] == view.entries[gi].t_new);
			end

			// Free rows may hold stale tags
			assign cam_hits[gi] = view.entries[gi].busy && (|match[gi]);
		end
	endgenerate

endmodule

`default_nettype wire

// ==== logic/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

	// Physical register file size
	localparam int NUM_PHYS_REG = 64;
	localparam int PHYS_REG_W = $clog2(NUM_PHYS_REG);

	// Instruction word width
	localparam int INST_W = 32;

	// Tag into the physical register file
	typedef logic [PHYS_REG_W-1:0] phys_reg_t;

	// Raw instruction word as fetched
	typedef logic [INST_W-1:0] inst_t;

	// addi x0, x0, 0
	localparam inst_t noop_inst = 32'h0000_0013;

	// Register zero is never renamed
	localparam phys_reg_t zero_reg = '0;

endpackage

`default_nettype wire

// ==== logic/retire_select.sv ====
`timescale 1ns/1ns
`default_nettype none

module retire_select import isa_pkg::*, rob_pkg::*; #(
	parameter int ROB_SIZE = 8,
	parameter int SS_SIZE = 2
) (
	input logic enable,
	input logic flush,
	input logic [ROB_SIZE-1:0] cam_hits,
	output logic [SS_SIZE-1:0] retire_valid,
	output retire_slot_t [SS_SIZE-1:0] retire_slot,
	rob_view_if.retire view
);

	localparam int IDX_W = $clog2(ROB_SIZE);
	localparam int CNT_W = $clog2(SS_SIZE) + 1;

	localparam retire_slot_t empty_slot = '{
		t_new: '0,
		t_old: '0,
		halt: 1'b0,
		take_branch: 1'b0,
		opcode: noop_inst
	};

	logic [ROB_SIZE-1:0] ready_now; // Stored ready or hit this cycle
	logic [SS_SIZE-1:0][IDX_W-1:0] pos;
	logic [CNT_W-1:0] count;
	logic [ROB_SIZE-1:0] mask;
	logic run;

	genvar gi;
	generate
		for (gi = 0; gi < ROB_SIZE; gi++) begin : g_ready
			assign ready_now[gi] = view.entries[gi].busy
				&& (view.entries[gi].ready || cam_hits[gi]);
		end
	endgenerate

	always_comb begin
		run = enable && !flush;
		count = '0;
		mask = '0;
		for (int k = 0; k < SS_SIZE; k++) begin
			pos[k] = view.head + IDX_W'(k);
			run = run && ready_now[pos[k]]; // First gap ends the group
			retire_valid[k] = run;
			retire_slot[k] = empty_slot;
			if (run) begin
				retire_slot[k].t_new = view.entries[pos[k]].t_new;
				retire_slot[k].t_old = view.entries[pos[k]].t_old;
				retire_slot[k].halt = view.entries[pos[k]].halt;
				retire_slot[k].take_branch = view.entries[pos[k]].take_branch;
				retire_slot[k].opcode = view.entries[pos[k]].opcode;
				mask[pos[k]] = 1'b1;
				count = count + 1'b1;
			end
		end
	end

	assign view.retire_count = count;
	assign view.retire_mask = mask;

endmodule

`default_nettype wire

// ==== logic/rob_pkg.sv ====
`default_nettype none

package rob_pkg;

	// One buffer row
	typedef struct packed {
		logic busy; // Row holds a live instruction
		logic ready; // Result seen on the CDB
		logic halt;
		logic take_branch;
		isa_pkg::phys_reg_t t_new; // Destination tag written by this instruction
		isa_pkg::phys_reg_t t_old; // Previous mapping, freed at retire
		isa_pkg::inst_t opcode;
	} rob_entry_t;

	// What leaves the buffer at retire
	typedef struct packed {
		isa_pkg::phys_reg_t t_new;
		isa_pkg::phys_reg_t t_old;
		logic halt;
		logic take_branch;
		isa_pkg::inst_t opcode;
	} retire_slot_t;

endpackage

`default_nettype wire

// ==== logic/rob_table.sv ====
`timescale 1ns/1ns
`default_nettype none

module rob_table import isa_pkg::*, rob_pkg::*; #(
	parameter int ROB_SIZE = 8,
	parameter int SS_SIZE = 2
) (
	input logic clock,
	input logic reset,
	input logic enable,
	input logic flush,
	input logic [SS_SIZE-1:0] dispatch_valid,
	input phys_reg_t [SS_SIZE-1:0] dispatch_t_new,
	input phys_reg_t [SS_SIZE-1:0] dispatch_t_old,
	input logic [SS_SIZE-1:0] dispatch_halt,
	input inst_t [SS_SIZE-1:0] dispatch_opcode,
	input logic take_branch,
	input logic [ROB_SIZE-1:0] cam_hits,
	output logic [$clog2(ROB_SIZE):0] free_rows,
	output logic full,
	rob_view_if.tbl view
);

	localparam int IDX_W = $clog2(ROB_SIZE);
	localparam int CNT_W = $clog2(SS_SIZE) + 1;

	rob_entry_t [ROB_SIZE-1:0] rows;
	logic [IDX_W-1:0] head;
	logic [IDX_W-1:0] tail; // Next row to allocate

	logic [SS_SIZE-1:0] take; // Lanes accepted this cycle
	logic [SS_SIZE-1:0][IDX_W-1:0] slot;
	logic [CNT_W-1:0] accept_count;

	assign view.entries = rows;
	assign view.head = head;

	assign full = (free_rows == '0);

	// Lanes fill consecutive tail slots, skipping idle lanes
	always_comb begin
		take = '0;
		accept_count = '0;
		for (int k = 0; k < SS_SIZE; k++) begin
			slot[k] = tail + IDX_W'(accept_count);
			if (enable && !flush && dispatch_valid[k] &&
					((IDX_W+1)'(accept_count) < free_rows)) begin
				take[k] = 1'b1;
				accept_count = accept_count + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset || flush) begin
			rows <= '0;
			head <= '0;
			tail <= '0;
			free_rows <= (IDX_W+1)'(ROB_SIZE);
		end else begin
			for (int i = 0; i < ROB_SIZE; i++) begin
				if (cam_hits[i])
					rows[i].ready <= 1'b1;
				if (view.retire_mask[i]) begin
					rows[i].busy <= 1'b0;
					rows[i].ready <= 1'b0;
				end
			end

			// Dispatch targets only rows that were free at cycle start
			for (int k = 0; k < SS_SIZE; k++) begin
				if (take[k]) begin
					rows[slot[k]].busy <= 1'b1;
					rows[slot[k]].ready <= 1'b0;
					rows[slot[k]].halt <= dispatch_halt[k];
					rows[slot[k]].take_branch <= take_branch;
					rows[slot[k]].t_new <= dispatch_t_new[k];
					rows[slot[k]].t_old <= dispatch_t_old[k];
					rows[slot[k]].opcode <= dispatch_opcode[k];
				end
			end

			head <= head + IDX_W'(view.retire_count); // Wraps at ROB_SIZE
			tail <= tail + IDX_W'(accept_count);
			free_rows <= free_rows + (IDX_W+1)'(view.retire_count)
				- (IDX_W+1)'(accept_count);
		end
	end

endmodule

`default_nettype wire

// ==== logic/rob_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module rob_top import isa_pkg::*, rob_pkg::*; #(
	parameter int ROB_SIZE = 8,
	parameter int SS_SIZE = 2
) (
	input logic clock,
	input logic reset,
	input logic enable,
	input logic flush, // Mispredicted branch
	input logic [SS_SIZE-1:0] dispatch_valid,
	input phys_reg_t [SS_SIZE-1:0] dispatch_t_new, // From the free list
	input phys_reg_t [SS_SIZE-1:0] dispatch_t_old, // From the map table
	input logic [SS_SIZE-1:0] dispatch_halt,
	input inst_t [SS_SIZE-1:0] dispatch_opcode,
	input logic take_branch,
	input logic [SS_SIZE-1:0] cdb_valid,
	input phys_reg_t [SS_SIZE-1:0] cdb_tag,
	output logic [SS_SIZE-1:0] retire_valid,
	output retire_slot_t [SS_SIZE-1:0] retire_slot,
	output logic [$clog2(ROB_SIZE):0] free_rows,
	output logic full
);

	logic [ROB_SIZE-1:0] cam_hits;

	rob_view_if #(.ROB_SIZE(ROB_SIZE), .SS_SIZE(SS_SIZE)) view ();

	rob_table #(.ROB_SIZE(ROB_SIZE), .SS_SIZE(SS_SIZE)) u_table (
		.clock(clock),
		.reset(reset),
		.enable(enable),
		.flush(flush),
		.dispatch_valid(dispatch_valid),
		.dispatch_t_new(dispatch_t_new),
		.dispatch_t_old(dispatch_t_old),
		.dispatch_halt(dispatch_halt),
		.dispatch_opcode(dispatch_opcode),
		.take_branch(take_branch),
		.cam_hits(cam_hits),
		.free_rows(free_rows),
		.full(full),
		.view(view.tbl)
	);

	completion_cam #(.ROB_SIZE(ROB_SIZE), .SS_SIZE(SS_SIZE)) u_cam (
		.cdb_valid(cdb_valid),
		.cdb_tag(cdb_tag),
		.cam_hits(cam_hits),
		.view(view.cam)
	);

	retire_select #(.ROB_SIZE(ROB_SIZE), .SS_SIZE(SS_SIZE)) u_retire (
		.enable(enable),
		.flush(flush),
		.cam_hits(cam_hits),
		.retire_valid(retire_valid),
		.retire_slot(retire_slot),
		.view(view.retire)
	);

endmodule

`default_nettype wire

// ==== logic/rob_view_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface rob_view_if import rob_pkg::*; #(
	parameter int ROB_SIZE = 8,
	parameter int SS_SIZE = 2
) ();

	localparam int IDX_W = $clog2(ROB_SIZE);
	localparam int CNT_W = $clog2(SS_SIZE) + 1;

	rob_entry_t [ROB_SIZE-1:0] entries;
	logic [IDX_W-1:0] head; // Oldest row
	logic [CNT_W-1:0] retire_count; // Rows leaving this cycle
	logic [ROB_SIZE-1:0] retire_mask;

	modport tbl (output entries, output head, input retire_count, input retire_mask);
	modport cam (input entries);
	modport retire (input entries, input head, output retire_count, output retire_mask);

endinterface

`default_nettype wire

// ==== project.f ====
logic/isa_pkg.sv
logic/rob_pkg.sv
logic/rob_view_if.sv
logic/completion_cam.sv
logic/retire_select.sv
logic/rob_table.sv
logic/rob_top.sv
tests/rob_checker.sv
tests/rob_tb.sv

// ==== tests/rob_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module rob_checker #(
	parameter int ROB_SIZE = 8,
	parameter int SS_SIZE = 2
) (
	input logic clock,
	input logic reset,
	input logic [SS_SIZE-1:0] retire_valid,
	input logic [$clog2(ROB_SIZE):0] free_rows,
	input logic full
);

	full_matches_free: assert property (@(posedge clock) disable iff (reset)
		full == (free_rows == '0))
		else $error("full does not match free_rows");

	// All ones from lane 0 up, then zeros
	retire_prefix: assert property (@(posedge clock) disable iff (reset)
		(retire_valid & (retire_valid + SS_SIZE'(1))) == '0)
		else $error("retire_valid is not a contiguous prefix");

	free_in_range: assert property (@(posedge clock) disable iff (reset)
		free_rows <= ($clog2(ROB_SIZE) + 1)'(ROB_SIZE))
		else $error("free_rows exceeds the buffer size");

	quiet_after_reset: assert property (@(posedge clock)
		$fell(reset) |-> retire_valid == '0)
		else $error("retire lane valid right after reset");

endmodule

bind rob_top rob_checker #(.ROB_SIZE(ROB_SIZE), .SS_SIZE(SS_SIZE)) checker_i (
	.clock(clock),
	.reset(reset),
	.retire_valid(retire_valid),
	.free_rows(free_rows),
	.full(full)
);

`default_nettype wire

// ==== tests/rob_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module rob_tb import isa_pkg::*, rob_pkg::*; ();

	localparam int ROB_SIZE = 8;
	localparam int SS_SIZE = 2;
	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 4;
	localparam int FILL_CYCLES = 12; // Dispatch with the CDB idle
	localparam int NUM_CYCLES = 4000;
	localparam int TIMEOUT_NS = (NUM_CYCLES + RESET_CYCLES + 50) * CLK_PERIOD;
	localparam int FREE_W = $clog2(ROB_SIZE) + 1;
	localparam retire_slot_t empty_slot = '{t_new: '0, t_old: '0, halt: 1'b0,
		take_branch: 1'b0, opcode: noop_inst};

	logic clock;
	logic reset;
	logic enable;
	logic flush;
	logic [SS_SIZE-1:0] dispatch_valid;
	phys_reg_t [SS_SIZE-1:0] dispatch_t_new;
	phys_reg_t [SS_SIZE-1:0] dispatch_t_old;
	logic [SS_SIZE-1:0] dispatch_halt;
	inst_t [SS_SIZE-1:0] dispatch_opcode;
	logic take_branch;
	logic [SS_SIZE-1:0] cdb_valid;
	phys_reg_t [SS_SIZE-1:0] cdb_tag;
	logic [SS_SIZE-1:0] retire_valid;
	retire_slot_t [SS_SIZE-1:0] retire_slot;
	logic [FREE_W-1:0] free_rows;
	logic full;

	retire_slot_t model_q[$]; // Oldest first
	bit model_ready[$];
	logic [31:0] rng_state;

	rob_top #(.ROB_SIZE(ROB_SIZE), .SS_SIZE(SS_SIZE)) dut_i (
		.clock(clock),
		.reset(reset),
		.enable(enable),
		.flush(flush),
		.dispatch_valid(dispatch_valid),
		.dispatch_t_new(dispatch_t_new),
		.dispatch_t_old(dispatch_t_old),
		.dispatch_halt(dispatch_halt),
		.dispatch_opcode(dispatch_opcode),
		.take_branch(take_branch),
		.cdb_valid(cdb_valid),
		.cdb_tag(cdb_tag),
		.retire_valid(retire_valid),
		.retire_slot(retire_slot),
		.free_rows(free_rows),
		.full(full)
	);

	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng_state;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rng_state = x;
		return x;
	endfunction

	// Any valid CDB lane carrying this tag
	function automatic bit on_cdb(input phys_reg_t tag);
		bit hit;
		hit = 1'b0;
		for (int k = 0; k < SS_SIZE; k++)
			if (cdb_valid[k] && cdb_tag[k] == tag)
				hit = 1'b1;
		return hit;
	endfunction

	task automatic report_error(input string name, input logic [63:0] got, input logic [63:0] exp);
		$display("** Error: %s got 0x%h expected 0x%h at %0t ns", name, got, exp, $time);
		$display("SOME TESTS FAILED");
		$fatal(1, "mismatch on %s", name);
	endtask

	task automatic check_retire(input int lane, input logic got_valid, input retire_slot_t got,
			input logic exp_valid, input retire_slot_t exp);
		if (got_valid !== exp_valid)
			report_error($sformatf("retire_valid[%0d]", lane), 64'(got_valid), 64'(exp_valid));
		if (got !== exp)
			report_error($sformatf("retire_slot[%0d]", lane), 64'(got), 64'(exp));
	endtask

	task automatic check_count(input logic [FREE_W-1:0] got_free, input logic got_full,
			input logic [FREE_W-1:0] exp_free, input logic exp_full);
		if (got_free !== exp_free)
			report_error("free_rows", 64'(got_free), 64'(exp_free));
		if (got_full !== exp_full)
			report_error("full", 64'(got_full), 64'(exp_full));
	endtask

	task automatic drive_inputs(input int cycle);
		logic [31:0] r;
		bit traffic;
		logic [SS_SIZE-1:0] valid_d;
		logic [SS_SIZE-1:0] halt_d;
		logic [SS_SIZE-1:0] cdb_d;
		phys_reg_t [SS_SIZE-1:0] new_d;
		phys_reg_t [SS_SIZE-1:0] old_d;
		phys_reg_t [SS_SIZE-1:0] tag_d;
		inst_t [SS_SIZE-1:0] op_d;
		traffic = (cycle >= FILL_CYCLES);
		r = next_random();
		enable <= !traffic || (r[2:0] != 3'd0);
		flush <= traffic && (r[9:5] == 5'd0);
		take_branch <= r[10];
		for (int k = 0; k < SS_SIZE; k++) begin
			r = next_random();
			valid_d[k] = r[0] | r[1]; // May exceed free_rows
			new_d[k] = r[7:2];
			old_d[k] = r[13:8];
			halt_d[k] = (r[18:14] == 5'd0);
			op_d[k] = next_random();
			r = next_random();
			cdb_d[k] = traffic && (r[1:0] != 2'd0);
			if (model_q.size() > 0 && r[4:2] == 3'd0)
				tag_d[k] = model_q[0].t_new; // Head completes this cycle
			else if (model_q.size() > 0 && r[5])
				tag_d[k] = model_q[r[15:8] % model_q.size()].t_new;
			else
				tag_d[k] = r[21:16];
		end
		dispatch_valid <= valid_d;
		dispatch_t_new <= new_d;
		dispatch_t_old <= old_d;
		dispatch_halt <= halt_d;
		dispatch_opcode <= op_d;
		cdb_valid <= cdb_d;
		cdb_tag <= tag_d;
	endtask

	// Expected group is the in-order prefix of ready entries
	task automatic check_outputs(output int n);
		int size;
		retire_slot_t exp;
		size = model_q.size();
		n = 0;
		if (enable && !flush)
			while (n < SS_SIZE && n < size && (model_ready[n] || on_cdb(model_q[n].t_new)))
				n++;
		for (int k = 0; k < SS_SIZE; k++) begin
			exp = (k < n) ? model_q[k] : empty_slot;
			check_retire(k, retire_valid[k], retire_slot[k], k < n, exp);
		end
		check_count(free_rows, full, FREE_W'(ROB_SIZE - size), size == ROB_SIZE);
	endtask

	task automatic update_model(input int n);
		int free_start;
		int accepted;
		retire_slot_t s;
		free_start = ROB_SIZE - model_q.size(); // Rows freed this cycle not reusable yet
		accepted = 0;
		if (flush) begin
			model_q.delete();
			model_ready.delete();
		end else begin
			foreach (model_q[i])
				if (on_cdb(model_q[i].t_new))
					model_ready[i] = 1'b1;
			repeat (n) begin
				void'(model_q.pop_front());
				void'(model_ready.pop_front());
			end
			for (int k = 0; k < SS_SIZE; k++)
				if (enable && dispatch_valid[k] && accepted < free_start) begin
					s = '{t_new: dispatch_t_new[k], t_old: dispatch_t_old[k],
						halt: dispatch_halt[k], take_branch: take_branch,
						opcode: dispatch_opcode[k]};
					model_q.push_back(s);
					model_ready.push_back(1'b0);
					accepted++;
				end
		end
	endtask

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
		$display("SOME TESTS FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin
		int n;
		rng_state = 32'd1984;
		reset = 1'b1;
		enable = 1'b0;
		flush = 1'b0;
		dispatch_valid = '0;
		dispatch_t_new = '0;
		dispatch_t_old = '0;
		dispatch_halt = '0;
		dispatch_opcode = '0;
		take_branch = 1'b0;
		cdb_valid = '0;
		cdb_tag = '0;
		repeat (RESET_CYCLES - 1) @(posedge clock);
		for (int cycle = 0; cycle < NUM_CYCLES; cycle++) begin
			@(posedge clock);
			reset <= 1'b0; // Edge of cycle 0 is the last reset edge
			drive_inputs(cycle);
			@(negedge clock);
			check_outputs(n);
			update_model(n);
		end
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire
